//--- common/dlx_pkg.sv
package dlx_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [5:0] OP_RTYPE = 6'h00;

	// R-type function codes
	localparam logic [5:0] FUNC_SLL = 6'h04;
	localparam logic [5:0] FUNC_SRL = 6'h06;
	localparam logic [5:0] FUNC_SRA = 6'h07;
	localparam logic [5:0] FUNC_ADD = 6'h20;
	localparam logic [5:0] FUNC_SUB = 6'h22;
	localparam logic [5:0] FUNC_AND = 6'h24;
	localparam logic [5:0] FUNC_OR  = 6'h25;
	localparam logic [5:0] FUNC_XOR = 6'h26;
	localparam logic [5:0] FUNC_SEQ = 6'h28;
	localparam logic [5:0] FUNC_SNE = 6'h29;
	localparam logic [5:0] FUNC_SLT = 6'h2a;
	localparam logic [5:0] FUNC_SGT = 6'h2b;
	localparam logic [5:0] FUNC_SLE = 6'h2c;
	localparam logic [5:0] FUNC_SGE = 6'h2d;

	// Immediate opcodes, one per ALU function
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_SUBI = 6'h0a;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI  = 6'h0d;
	localparam logic [5:0] OP_XORI = 6'h0e;
	localparam logic [5:0] OP_SLLI = 6'h14;
	localparam logic [5:0] OP_SRLI = 6'h16;
	localparam logic [5:0] OP_SRAI = 6'h17;
	localparam logic [5:0] OP_SEQI = 6'h18;
	localparam logic [5:0] OP_SNEI = 6'h19;
	localparam logic [5:0] OP_SLTI = 6'h1a;
	localparam logic [5:0] OP_SGTI = 6'h1b;
	localparam logic [5:0] OP_SLEI = 6'h1c;
	localparam logic [5:0] OP_SGEI = 6'h1d;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SEQ,
		ALU_SNE,
		ALU_SLT,
		ALU_SGT,
		ALU_SLE,
		ALU_SGE
	} alu_func_e;

	// Same 32-bit word, R-type or I-type field layout
	typedef union packed {
		struct packed {
			logic [5:0]            opcode;
			logic [REG_ADDR_W-1:0] rs1;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rd;
			logic [4:0]            shamt;
			logic [5:0]            func;
		} r;
		struct packed {
			logic [5:0]            opcode;
			logic [REG_ADDR_W-1:0] rs1;
			logic [REG_ADDR_W-1:0] rd;
			logic [15:0]           imm;
		} i;
	} dlx_instr_u;

endpackage

//--- dv/tb_dlx_model.svh
// Expected outputs for one issue slot
typedef struct packed {
	logic                  valid;
	logic                  illegal;
	logic [31:0]           result;
	logic [REG_ADDR_W-1:0] rd;
	logic                  ovf;
} exp_t;

logic [31:0] shadow_regs [0:31] = '{default: '0};	// r0 entry stays zero
exp_t        exp_q [$];

// DLX encodings per ALU function
function automatic logic [5:0] r_code(input alu_func_e f);
	case (f)
		ALU_ADD: return 6'h20;
		ALU_SUB: return 6'h22;
		ALU_AND: return 6'h24;
		ALU_OR:  return 6'h25;
		ALU_XOR: return 6'h26;
		ALU_SLL: return 6'h04;
		ALU_SRL: return 6'h06;
		ALU_SRA: return 6'h07;
		ALU_SEQ: return 6'h28;
		ALU_SNE: return 6'h29;
		ALU_SLT: return 6'h2a;
		ALU_SGT: return 6'h2b;
		ALU_SLE: return 6'h2c;
		default: return 6'h2d;	// SGE
	endcase
endfunction

function automatic logic [5:0] i_code(input alu_func_e f);
	case (f)
		ALU_ADD: return 6'h08;
		ALU_SUB: return 6'h0a;
		ALU_AND: return 6'h0c;
		ALU_OR:  return 6'h0d;
		ALU_XOR: return 6'h0e;
		ALU_SLL: return 6'h14;
		ALU_SRL: return 6'h16;
		ALU_SRA: return 6'h17;
		ALU_SEQ: return 6'h18;
		ALU_SNE: return 6'h19;
		ALU_SLT: return 6'h1a;
		ALU_SGT: return 6'h1b;
		ALU_SLE: return 6'h1c;
		default: return 6'h1d;	// SGEI
	endcase
endfunction

// Index of the matching ALU function or -1 for an unlisted encoding
function automatic int find_func(input dlx_instr_u ins);
	int hit;
	hit = -1;
	for (int k = 0; k < 14; k++) begin
		if (ins.r.opcode == OP_RTYPE && ins.r.func == r_code(alu_func_e'(k)))
			hit = k;
		else if (ins.i.opcode != OP_RTYPE && ins.i.opcode == i_code(alu_func_e'(k)))
			hit = k;
	end
	return hit;
endfunction

// Returns {overflow, result}
function automatic logic [32:0] alu_model(input alu_func_e f, input logic [31:0] a,
		input logic [31:0] b);
	logic [31:0] y;
	logic        v;
	v = 1'b0;
	case (f)
		ALU_ADD: begin
			y = a + b;
			v = (a[31] == b[31]) && (y[31] != a[31]);
		end
		ALU_SUB: begin
			y = a - b;
			v = (a[31] != b[31]) && (y[31] != a[31]);
		end
		ALU_AND: y = a & b;
		ALU_OR:  y = a | b;
		ALU_XOR: y = a ^ b;
		ALU_SLL: y = a << b[4:0];
		ALU_SRL: y = a >> b[4:0];
		ALU_SRA: y = $signed(a) >>> b[4:0];
		ALU_SEQ: y = 32'($signed(a) == $signed(b));
		ALU_SNE: y = 32'($signed(a) != $signed(b));
		ALU_SLT: y = 32'($signed(a) < $signed(b));
		ALU_SGT: y = 32'($signed(a) > $signed(b));
		ALU_SLE: y = 32'($signed(a) <= $signed(b));
		default: y = 32'($signed(a) >= $signed(b));
	endcase
	return {v, y};
endfunction

// Executes one instruction on the shadow registers
function automatic exp_t model_step(input dlx_instr_u ins);
	exp_t        e;
	int          k;
	alu_func_e   f;
	logic [31:0] a;
	logic [31:0] b;
	logic [32:0] r;
	logic [4:0]  rd;
	e = '0;
	k = find_func(ins);
	if (k < 0) begin
		e.illegal = 1'b1;
		return e;
	end
	f = alu_func_e'(k);
	a = shadow_regs[ins.r.rs1];
	if (ins.r.opcode == OP_RTYPE) begin
		b  = shadow_regs[ins.r.rs2];
		rd = ins.r.rd;
	end else begin
		rd = ins.i.rd;
		if (f inside {ALU_ADD, ALU_SUB, ALU_SEQ, ALU_SNE, ALU_SLT, ALU_SGT, ALU_SLE, ALU_SGE})
			b = {{16{ins.i.imm[15]}}, ins.i.imm};
		else
			b = {16'b0, ins.i.imm};	// Logic and shift immediates
	end
	r = alu_model(f, a, b);
	e.valid  = 1'b1;
	e.result = r[31:0];
	e.ovf    = r[32];
	e.rd     = rd;
	if (rd != 5'd0)
		shadow_regs[rd] = r[31:0];
	return e;
endfunction

//--- dv/tb_dlx_exec.sv
`timescale 1ns/1ns

module tb_dlx_exec;

	import dlx_pkg::*;

	localparam int N_DIRECTED = 54;
	localparam int N_ADDSUB   = 40;
	localparam int N_LOGIC    = 60;
	localparam int N_SETIF    = 6 * 10;	// Reload, three compares, two random ops
	localparam int N_CHAIN    = 100;
	localparam int N_ILLEGAL  = 20;
	localparam int N_INSTR    = N_DIRECTED + N_ADDSUB + N_LOGIC + N_SETIF + N_CHAIN
		+ 3 * N_ILLEGAL;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  instr_valid;
	dlx_instr_u            instr;
	logic                  result_valid;
	logic [XLEN-1:0]       result;
	logic [REG_ADDR_W-1:0] result_rd;
	logic                  overflow;
	logic                  illegal;
	logic [15:0]           lfsr_state;
	logic [4:0]            last_rd;

	`include "tb_dlx_model.svh"

	dlx_exec_unit #(
		.XLEN(XLEN)
	) u_dut (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.result_valid(result_valid),
		.result      (result),
		.result_rd   (result_rd),
		.overflow    (overflow),
		.illegal     (illegal)
	);

	always #5 clk = ~clk;

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic dlx_instr_u mk_r(input logic [5:0] fc, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		dlx_instr_u ins;
		ins.r.opcode = OP_RTYPE;
		ins.r.rs1    = rs1;
		ins.r.rs2    = rs2;
		ins.r.rd     = rd;
		ins.r.shamt  = '0;
		ins.r.func   = fc;
		return ins;
	endfunction

	function automatic dlx_instr_u mk_i(input logic [5:0] op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [15:0] imm);
		dlx_instr_u ins;
		ins.i.opcode = op;
		ins.i.rs1    = rs1;
		ins.i.rd     = rd;
		ins.i.imm    = imm;
		return ins;
	endfunction

	task automatic check_word(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display("tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] got,
			input logic [REG_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display("tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display("tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_pending();
		exp_t e;
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			check_bit("result_valid", result_valid, e.valid);
			check_bit("illegal", illegal, e.illegal);
			if (e.valid) begin
				check_word("result", result, e.result);
				check_reg("result_rd", result_rd, e.rd);
				check_bit("overflow", overflow, e.ovf);
			end
		end
	endtask

	// Check the previous slot and drive the next one at the falling edge
	task automatic issue(input dlx_instr_u ins, input logic valid);
		exp_t e;
		@(negedge clk);
		check_pending();
		instr_valid = valid;
		instr       = ins;
		e = '0;
		if (valid)
			e = model_step(ins);
		exp_q.push_back(e);
	endtask

	task automatic issue_random_op(input int k_lo, input int k_hi, input logic [4:0] src);
		alu_func_e   f;
		logic [4:0]  rd;
		logic [4:0]  rs2;
		logic [15:0] imm;
		f   = alu_func_e'(k_lo + int'(rand_bits(8)) % (k_hi - k_lo + 1));
		rd  = 5'(rand_bits(5));
		rs2 = 5'(rand_bits(5));
		imm = 16'(rand_bits(16));
		if (rand_bits(1)) begin
			issue(mk_r(r_code(f), rd, src, rs2), 1'b1);
		end else begin
			issue(mk_i(i_code(f), rd, src, imm), 1'b1);
		end
		last_rd = rd;
	endtask

	// r1 = 7fffffff, r2 = 80000000, r5 copy of r1
	task automatic load_extremes();
		issue(mk_i(OP_ADDI, 5'd1, 5'd0, 16'hffff), 1'b1);
		issue(mk_i(OP_SRLI, 5'd1, 5'd1, 16'd1), 1'b1);
		issue(mk_i(OP_ADDI, 5'd2, 5'd0, 16'd1), 1'b1);
		issue(mk_i(OP_SLLI, 5'd2, 5'd2, 16'd31), 1'b1);
		issue(mk_r(FUNC_ADD, 5'd5, 5'd1, 5'd0), 1'b1);
	endtask

	task automatic issue_illegal();
		dlx_instr_u ins;
		ins = rand_bits(32);
		if (rand_bits(1)) begin
			ins.r.opcode = OP_RTYPE;
			while (find_func(ins) >= 0)
				ins.r.func = 6'(rand_bits(6));
		end else begin
			while (ins.i.opcode == OP_RTYPE || find_func(ins) >= 0)
				ins.i.opcode = 6'(rand_bits(6));
		end
		issue(ins, 1'b1);
		// Read back both possible destinations through r0
		issue(mk_r(FUNC_ADD, 5'd0, ins.r.rd, 5'd0), 1'b1);
		issue(mk_r(FUNC_ADD, 5'd0, ins.i.rd, 5'd0), 1'b1);
	endtask

	initial begin
		#((N_INSTR + 20) * 10);
		$display("tests failed");
		$fatal(1, "Watchdog timeout, the test sequence did not finish in time");
	end

	initial begin
		lfsr_state  = 16'd52294;
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		last_rd     = 5'd1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		issue('0, 1'b0);	// Outputs quiet after reset

		// Register init and r0
		for (int r = 1; r < 32; r++)
			issue(mk_i(OP_ADDI, 5'(r), 5'd0, 16'(rand_bits(16))), 1'b1);
		issue(mk_i(OP_ADDI, 5'd0, 5'd0, 16'h1234), 1'b1);
		issue(mk_r(FUNC_ADD, 5'd7, 5'd0, 5'd0), 1'b1);

		// Add and subtract
		repeat (N_ADDSUB)
			issue_random_op(0, 1, 5'(rand_bits(5)));
		load_extremes();
		issue(mk_r(FUNC_ADD, 5'd3, 5'd1, 5'd1), 1'b1);
		issue(mk_r(FUNC_ADD, 5'd3, 5'd1, 5'd2), 1'b1);
		issue(mk_r(FUNC_ADD, 5'd3, 5'd2, 5'd2), 1'b1);
		issue(mk_r(FUNC_SUB, 5'd3, 5'd2, 5'd1), 1'b1);
		issue(mk_r(FUNC_SUB, 5'd3, 5'd1, 5'd2), 1'b1);
		issue(mk_i(OP_ADDI, 5'd3, 5'd1, 16'd1), 1'b1);
		issue(mk_i(OP_SUBI, 5'd3, 5'd2, 16'd1), 1'b1);

		// Logic and shifts
		repeat (N_LOGIC)
			issue_random_op(2, 7, 5'(rand_bits(5)));
		load_extremes();
		issue(mk_r(FUNC_SRA, 5'd4, 5'd2, 5'd1), 1'b1);	// Shift by 31 gives all ones
		issue(mk_i(OP_SRAI, 5'd4, 5'd2, 16'd5), 1'b1);

		// Set-if with overflowing differences
		for (int k = 8; k < 14; k++) begin
			load_extremes();	// Random ops below may overwrite r1, r2 or r5
			issue(mk_r(r_code(alu_func_e'(k)), 5'd6, 5'd1, 5'd2), 1'b1);
			issue(mk_r(r_code(alu_func_e'(k)), 5'd6, 5'd2, 5'd1), 1'b1);
			issue(mk_r(r_code(alu_func_e'(k)), 5'd6, 5'd1, 5'd5), 1'b1);
			issue_random_op(k, k, 5'd2);
			issue_random_op(k, k, 5'(rand_bits(5)));
		end

		// Dependent stream at one instruction per cycle
		repeat (N_CHAIN) begin
			if (rand_bits(1))
				issue_random_op(0, 13, last_rd);
			else
				issue_random_op(0, 13, 5'(rand_bits(5)));
		end

		repeat (N_ILLEGAL)
			issue_illegal();

		issue('0, 1'b0);
		@(negedge clk);
		check_pending();
		$display("all tests passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+dv
common/dlx_pkg.sv
hw/alu/cla_adder_32.sv
hw/alu/barrel_shifter_32.sv
hw/alu/alu_32.sv
hw/dlx_regfile.sv
hw/dlx_decode.sv
hw/dlx_exec_unit.sv
dv/tb_dlx_exec.sv

//--- hw/alu/alu_32.sv
`timescale 1ns/1ns

module alu_32 #(
	parameter int XLEN = dlx_pkg::XLEN
) (
	input  logic [XLEN-1:0]    a,
	input  logic [XLEN-1:0]    b,
	input  dlx_pkg::alu_func_e func,
	output logic [XLEN-1:0]    y,
	output logic               overflow
);

	import dlx_pkg::*;

	localparam int SHW = $clog2(XLEN);

	logic            is_add;
	logic [XLEN-1:0] b_adder;
	logic            c_in;
	logic [XLEN-1:0] sum;
	logic            add_ovf;
	logic            zero;
	logic            lt;
	logic            set_bit;
	logic [XLEN-1:0] sh_out;
	logic            sh_right;
	logic            sh_arith;

	// Everything but ADD goes through A + ~B + 1
	assign is_add  = (func == ALU_ADD);
	assign b_adder = is_add ? b : ~b;
	assign c_in    = ~is_add;

	cla_adder_32 #(
		.XLEN(XLEN)
	) u_adder (
		.a       (a),
		.b       (b_adder),
		.c_in    (c_in),
		.s       (sum),
		.c_out   (),
		.overflow(add_ovf)
	);

	assign sh_right = (func == ALU_SRL) || (func == ALU_SRA);
	assign sh_arith = (func == ALU_SRA);

	barrel_shifter_32 #(
		.XLEN(XLEN)
	) u_shifter (
		.a    (a),
		.shamt(b[SHW-1:0]),	// Low bits of B only
		.right(sh_right),
		.arith(sh_arith),
		.y    (sh_out)
	);

	assign zero = (sum == '0);

	// A < B signed, sign of A - B corrected when the difference overflows
	assign lt = sum[XLEN-1] ^ add_ovf;

	always_comb begin
		case (func)
			ALU_SEQ: set_bit = zero;
			ALU_SNE: set_bit = ~zero;
			ALU_SLT: set_bit = lt;
			ALU_SGT: set_bit = ~lt & ~zero;
			ALU_SLE: set_bit = lt | zero;
			ALU_SGE: set_bit = ~lt;
			default: set_bit = 1'b0;
		endcase
	end

	always_comb begin
		case (func)
			ALU_ADD, ALU_SUB: y = sum;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_SLL, ALU_SRL, ALU_SRA: y = sh_out;
			ALU_SEQ, ALU_SNE, ALU_SLT, ALU_SGT, ALU_SLE, ALU_SGE:
				y = {{(XLEN-1){1'b0}}, set_bit};
			default: y = '0;	// Two unused encodings
		endcase
	end

	assign overflow = (func == ALU_ADD || func == ALU_SUB) ? add_ovf : 1'b0;

	// Adder, shifter and select together give a known result for known inputs
	always_comb begin
		if (!$isunknown({a, b, func}))
			a_y_known: assert final (!$isunknown(y))
				else $error("alu_32: unknown result for func %0d", func);
	end

endmodule

//--- hw/alu/barrel_shifter_32.sv
`timescale 1ns/1ns

module barrel_shifter_32 #(
	parameter int XLEN = dlx_pkg::XLEN
) (
	input  logic [XLEN-1:0]         a,
	input  logic [$clog2(XLEN)-1:0] shamt,
	input  logic                    right,
	input  logic                    arith,
	output logic [XLEN-1:0]         y
);

	localparam int NSTG = $clog2(XLEN);

	logic [XLEN-1:0] a_rev;
	logic [XLEN-1:0] res_rev;
	logic [XLEN-1:0] stg [0:NSTG];
	logic            fill;

	if ((1 << NSTG) != XLEN) begin : g_bad_width
		$error("barrel_shifter_32: XLEN must be a power of two");
	end

	// Left shifts run through the right shifter on a bit-reversed word
	always_comb begin
		for (int i = 0; i < XLEN; i++) begin
			a_rev[i]   = a[XLEN-1-i];
			res_rev[i] = stg[NSTG][XLEN-1-i];
		end
	end

	assign fill   = right & arith & a[XLEN-1];	// Sign fill for SRA only
	assign stg[0] = right ? a : a_rev;

	for (genvar k = 0; k < NSTG; k++) begin : g_stage
		localparam int D = 2 ** k;
		assign stg[k+1] = shamt[k] ? {{D{fill}}, stg[k][XLEN-1:D]} : stg[k];
	end

	assign y = right ? stg[NSTG] : res_rev;

endmodule

//--- hw/alu/cla_adder_32.sv
`timescale 1ns/1ns

module cla_adder_32 #(
	parameter int XLEN = dlx_pkg::XLEN
) (
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  logic            c_in,
	output logic [XLEN-1:0] s,
	output logic            c_out,
	output logic            overflow
);

	localparam int NGRP = XLEN / 4;

	logic [XLEN-1:0] g;	// Bit generate
	logic [XLEN-1:0] p;	// Bit propagate
	logic [XLEN:0]   c;	// Carry into each bit, c[XLEN] is carry out
	logic [NGRP-1:0] grp_g;
	logic [NGRP-1:0] grp_p;

	if (XLEN % 4 != 0) begin : g_bad_width
		$error("cla_adder_32: XLEN must be a multiple of 4");
	end

	assign g = a & b;
	assign p = a ^ b;
	assign c[0] = c_in;

	for (genvar k = 0; k < NGRP; k++) begin : g_grp
		localparam int B = 4 * k;

		// Carries inside the group, all from c[B]
		assign c[B+1] = g[B] | (p[B] & c[B]);
		assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & c[B]);
		assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B])
			| (p[B+2] & p[B+1] & p[B] & c[B]);

		assign grp_g[k] = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1])
			| (p[B+3] & p[B+2] & p[B+1] & g[B]);
		assign grp_p[k] = &p[B+3:B];

		assign c[B+4] = grp_g[k] | (grp_p[k] & c[B]);	// Group carry out
	end

	assign s     = p ^ c[XLEN-1:0];
	assign c_out = c[XLEN];

	// Signed overflow when carry into sign differs from carry out
	assign overflow = c[XLEN-1] ^ c[XLEN];

endmodule

//--- hw/dlx_decode.sv
`timescale 1ns/1ns

module dlx_decode (
	input  dlx_pkg::dlx_instr_u            instr,
	output logic [dlx_pkg::REG_ADDR_W-1:0] rs1,
	output logic [dlx_pkg::REG_ADDR_W-1:0] rs2,
	output logic [dlx_pkg::REG_ADDR_W-1:0] rd,
	output logic [31:0]                    imm,
	output logic                           use_imm,
	output dlx_pkg::alu_func_e             func,
	output logic                           wr_en,
	output logic                           illegal
);

	import dlx_pkg::*;

	logic sext;	// Sign-extend the immediate

	always_comb begin
		rs1     = instr.r.rs1;	// Same field in both views
		rs2     = instr.r.rs2;
		rd      = instr.i.rd;
		use_imm = 1'b1;
		func    = ALU_ADD;
		sext    = 1'b1;
		wr_en   = 1'b1;
		illegal = 1'b0;
		if (instr.r.opcode == OP_RTYPE) begin
			rd      = instr.r.rd;
			use_imm = 1'b0;
			case (instr.r.func)
				FUNC_SLL: func = ALU_SLL;
				FUNC_SRL: func = ALU_SRL;
				FUNC_SRA: func = ALU_SRA;
				FUNC_ADD: func = ALU_ADD;
				FUNC_SUB: func = ALU_SUB;
				FUNC_AND: func = ALU_AND;
				FUNC_OR:  func = ALU_OR;
				FUNC_XOR: func = ALU_XOR;
				FUNC_SEQ: func = ALU_SEQ;
				FUNC_SNE: func = ALU_SNE;
				FUNC_SLT: func = ALU_SLT;
				FUNC_SGT: func = ALU_SGT;
				FUNC_SLE: func = ALU_SLE;
				FUNC_SGE: func = ALU_SGE;
				default: begin
					wr_en   = 1'b0;
					illegal = 1'b1;
				end
			endcase
		end else begin
			case (instr.i.opcode)
				OP_ADDI: func = ALU_ADD;
				OP_SUBI: func = ALU_SUB;
				OP_SEQI: func = ALU_SEQ;
				OP_SNEI: func = ALU_SNE;
				OP_SLTI: func = ALU_SLT;
				OP_SGTI: func = ALU_SGT;
				OP_SLEI: func = ALU_SLE;
				OP_SGEI: func = ALU_SGE;
				OP_ANDI: begin
					func = ALU_AND;
					sext = 1'b0;
				end
				OP_ORI: begin
					func = ALU_OR;
					sext = 1'b0;
				end
				OP_XORI: begin
					func = ALU_XOR;
					sext = 1'b0;
				end
				// Shifts only look at imm[4:0]
				OP_SLLI: begin
					func = ALU_SLL;
					sext = 1'b0;
				end
				OP_SRLI: begin
					func = ALU_SRL;
					sext = 1'b0;
				end
				OP_SRAI: begin
					func = ALU_SRA;
					sext = 1'b0;
				end
				default: begin
					wr_en   = 1'b0;
					illegal = 1'b1;
				end
			endcase
		end
	end

	assign imm = sext ? {{16{instr.i.imm[15]}}, instr.i.imm} : {16'b0, instr.i.imm};

	always_comb begin
		a_wr_xor_illegal: assert final (!(wr_en && illegal))
			else $error("dlx_decode: write enable on illegal instruction");
	end

endmodule

//--- hw/dlx_exec_unit.sv
`timescale 1ns/1ns

module dlx_exec_unit #(
	parameter int XLEN = dlx_pkg::XLEN
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           instr_valid,
	input  dlx_pkg::dlx_instr_u            instr,
	output logic                           result_valid,
	output logic [XLEN-1:0]                result,
	output logic [dlx_pkg::REG_ADDR_W-1:0] result_rd,
	output logic                           overflow,
	output logic                           illegal
);

	import dlx_pkg::*;

	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [REG_ADDR_W-1:0] rd;
	logic [31:0]           imm;
	logic                  use_imm;
	alu_func_e             dec_func;
	logic                  dec_wr_en;
	logic                  dec_illegal;
	logic                  wr_en;
	logic [XLEN-1:0]       op_a;
	logic [XLEN-1:0]       rd2;
	logic [XLEN-1:0]       op_b;
	logic [XLEN-1:0]       alu_y;
	logic                  alu_ovf;

	dlx_decode u_decode (
		.instr  (instr),
		.rs1    (rs1),
		.rs2    (rs2),
		.rd     (rd),
		.imm    (imm),
		.use_imm(use_imm),
		.func   (dec_func),
		.wr_en  (dec_wr_en),
		.illegal(dec_illegal)
	);

	assign wr_en = instr_valid & dec_wr_en;	// Same edge as result register

	dlx_regfile #(
		.XLEN(XLEN)
	) u_regfile (
		.clk    (clk),
		.rst    (rst),
		.rs1    (rs1),
		.rs2    (rs2),
		.wr_en  (wr_en),
		.wr_addr(rd),
		.wr_data(alu_y),
		.rd1    (op_a),
		.rd2    (rd2)
	);

	assign op_b = use_imm ? XLEN'(imm) : rd2;

	alu_32 #(
		.XLEN(XLEN)
	) u_alu (
		.a       (op_a),
		.b       (op_b),
		.func    (dec_func),
		.y       (alu_y),
		.overflow(alu_ovf)
	);

	// Result outputs, one cycle after the strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			illegal      <= 1'b0;
			result       <= '0;
			result_rd    <= '0;
			overflow     <= 1'b0;
		end else begin
			result_valid <= wr_en;
			illegal      <= instr_valid & dec_illegal;
			if (wr_en) begin
				result    <= alu_y;
				result_rd <= rd;
				overflow  <= alu_ovf;
			end
		end
	end

endmodule

//--- hw/dlx_regfile.sv
`timescale 1ns/1ns

module dlx_regfile #(
	parameter int XLEN = dlx_pkg::XLEN
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [dlx_pkg::REG_ADDR_W-1:0] rs1,
	input  logic [dlx_pkg::REG_ADDR_W-1:0] rs2,
	input  logic                          wr_en,
	input  logic [dlx_pkg::REG_ADDR_W-1:0] wr_addr,
	input  logic [XLEN-1:0]               wr_data,
	output logic [XLEN-1:0]               rd1,
	output logic [XLEN-1:0]               rd2
);

	import dlx_pkg::*;

	localparam int NREG = 2 ** REG_ADDR_W;

	// No storage behind r0
	logic [XLEN-1:0] regs [1:NREG-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Combinational reads, r0 reads as zero
	assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

	// Upstream must hold off writes while in reset
	a_no_wr_in_rst: assert property (@(posedge clk) rst |-> !wr_en)
		else $error("dlx_regfile: write request during reset");

endmodule
